//--- hdl/num_pkg.sv
// number-side definitions for the display path
// binary input width, digit count, saturation limit and bcd frame types
package num_pkg;

    localparam int VALUE_W    = 20;    // unsigned binary input width
    localparam int NUM_DIGITS = 6;     // digits on the display

    // largest value the six digits can show
    localparam logic [VALUE_W-1:0] VALUE_MAX = VALUE_W'(999999);

    // ------------------------------------------------------------------------
    // bcd types
    // ------------------------------------------------------------------------
    typedef logic [3:0] bcd_digit_t;

    // index 0 is the ones digit
    typedef bcd_digit_t [NUM_DIGITS-1:0] bcd_frame_t;

endpackage

//--- hdl/disp_pkg.sv
// display-side definitions
// digit codes, active-low segment and select types, segment table
package disp_pkg;

    // ------------------------------------------------------------------------
    // display codes, 0..9 are plain digits
    // ------------------------------------------------------------------------
    typedef logic [3:0] disp_code_t;

    localparam disp_code_t CODE_BLANK = 4'd10;
    localparam disp_code_t CODE_MINUS = 4'd11;

    typedef disp_code_t [num_pkg::NUM_DIGITS-1:0] code_frame_t;   // 24 bits

    // ------------------------------------------------------------------------
    // segment side, everything active low
    // ------------------------------------------------------------------------
    typedef logic [7:0] seg_t;                          // {dp, g, f, e, d, c, b, a}
    typedef logic [num_pkg::NUM_DIGITS-1:0] sel_t;      // bit i low selects digit i

    localparam seg_t SEG_BLANK = 8'hFF;
    localparam seg_t SEG_MINUS = 8'hBF;                 // g only

    // digit patterns with the point off
    localparam seg_t SEG_DIGIT [10] = '{
        8'hC0,      // 0
        8'hF9,      // 1
        8'hA4,      // 2
        8'hB0,      // 3
        8'h99,      // 4
        8'h92,      // 5
        8'h82,      // 6
        8'hF8,      // 7
        8'h80,      // 8
        8'h90       // 9
    };

endpackage

//--- hdl/bcd_frame_if.sv
// bcd frame link from the converter to the formatter
// valid/ready handshake, payload held stable until accepted
`timescale 1ns/100ps

interface bcd_frame_if;

    import num_pkg::*;

    logic                  valid;
    logic                  ready;
    bcd_frame_t            digits;     // [0] is the ones digit
    logic [NUM_DIGITS-1:0] point;      // point mask, bit i on digit i
    logic                  sign;       // show a minus sign

    // converter side
    modport src (
        output valid,
        output digits,
        output point,
        output sign,
        input  ready
    );

    // formatter side
    modport dst (
        input  valid,
        input  digits,
        input  point,
        input  sign,
        output ready
    );

endinterface

//--- hdl/seg_decoder.sv
// seven-segment decoder
// display code and point bit to an active-low segment pattern
`timescale 1ns/100ps

module seg_decoder (
    input  disp_pkg::disp_code_t   code,
    input  logic                   point_on,
    output disp_pkg::seg_t         seg
);

    import disp_pkg::*;

    logic is_digit;

    assign is_digit = (code <= 4'd9);

    always_comb begin
        if (is_digit) begin
            // point only ever lit together with a digit
            seg = SEG_DIGIT[code] & {~point_on, 7'h7F};
        end else if (code == CODE_MINUS) begin
            seg = SEG_MINUS;
        end else begin
            seg = SEG_BLANK;                    // CODE_BLANK and unused codes
        end
    end

endmodule

//--- hdl/bin_to_bcd.sv
// serial binary to bcd converter
// clamps the value to six digits, then runs one shift-and-add-3 step per clock
// and offers the digits with the captured point mask and sign
`timescale 1ns/100ps

module bin_to_bcd (
    input  logic                                dri_clk,
    input  logic                                rst_n,
    input  logic [num_pkg::VALUE_W-1:0]         value_data,
    input  logic [num_pkg::NUM_DIGITS-1:0]      value_point,
    input  logic                                value_sign,
    input  logic                                value_valid,
    output logic                                value_ready,
    bcd_frame_if.src                            frame
);

    import num_pkg::*;

    localparam int                STEP_W    = $clog2(VALUE_W);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(VALUE_W - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CONV,
        ST_DONE
    } state_t;

    state_t                    state;
    logic [STEP_W-1:0]         step;
    logic [VALUE_W-1:0]        bin_sr;          // binary bits still to shift in
    bcd_frame_t                bcd_acc;
    logic [4*NUM_DIGITS-1:0]   bcd_adj;         // digits after the add-3 pass
    logic [VALUE_W-1:0]        value_clamped;
    logic [NUM_DIGITS-1:0]     point_q;
    logic                      sign_q;
    logic                      take;

    assign take          = value_valid && value_ready;
    assign value_clamped = (value_data > VALUE_MAX) ? VALUE_MAX : value_data;

    // add 3 to every digit of 5 or more before the shift
    always_comb begin
        for (int i = 0; i < NUM_DIGITS; i++) begin
            bcd_adj[4*i +: 4] = (bcd_acc[i] >= 4'd5) ? bcd_acc[i] + 4'd3 : bcd_acc[i];
        end
    end

    // ------------------------------------------------------------------------
    // control
    // ------------------------------------------------------------------------
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            step  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (take) begin
                        state <= ST_CONV;
                        step  <= '0;
                    end
                end
                ST_CONV: begin
                    if (step == LAST_STEP) begin
                        state <= ST_DONE;       // last bit shifted in
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                ST_DONE: begin
                    if (frame.ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------------------
    always_ff @(posedge dri_clk) begin
        if (take) begin
            bin_sr  <= value_clamped;
            bcd_acc <= '0;
            point_q <= value_point;
            sign_q  <= value_sign;
        end else if (state == ST_CONV) begin
            bin_sr  <= {bin_sr[VALUE_W-2:0], 1'b0};
            bcd_acc <= {bcd_adj[4*NUM_DIGITS-2:0], bin_sr[VALUE_W-1]};
        end
    end

    assign value_ready  = (state == ST_IDLE);
    assign frame.valid  = (state == ST_DONE);
    assign frame.digits = bcd_acc;              // held while waiting for ready
    assign frame.point  = point_q;
    assign frame.sign   = sign_q;

endmodule

//--- hdl/digit_formatter.sv
// digit formatter
// blanks leading zeros, places the minus sign and keeps one frame pending
// until the scan wraps, so the shown frame never changes mid-scan
`timescale 1ns/100ps

module digit_formatter (
    input  logic                             dri_clk,
    input  logic                             rst_n,
    bcd_frame_if.dst                         frame,
    input  logic                             frame_wrap,
    output disp_pkg::code_frame_t            codes,
    output logic [num_pkg::NUM_DIGITS-1:0]   point
);

    import num_pkg::*;
    import disp_pkg::*;

    logic [2:0]              top_pos;      // highest shown position
    code_frame_t             fmt_codes;
    code_frame_t             pend_codes;
    logic [NUM_DIGITS-1:0]   pend_point;
    logic                    pend_full;
    code_frame_t             disp_codes;
    logic [NUM_DIGITS-1:0]   disp_point;

    // ------------------------------------------------------------------------
    // formatting rule, applied as the frame enters
    // ------------------------------------------------------------------------
    always_comb begin
        top_pos = 3'd0;
        for (int p = 1; p < NUM_DIGITS; p++) begin
            if (frame.digits[p] != 4'd0 || frame.point[p]) begin
                top_pos = 3'(p);
            end
        end
    end

    always_comb begin
        for (int p = 0; p < NUM_DIGITS; p++) begin
            if (p <= int'(top_pos)) begin
                fmt_codes[p] = frame.digits[p];
            end else if (frame.sign && p == int'(top_pos) + 1) begin
                fmt_codes[p] = CODE_MINUS;
            end else begin
                fmt_codes[p] = CODE_BLANK;      // sign falls off when all six are used
            end
        end
    end

    // ------------------------------------------------------------------------
    // pending register and display buffer
    // ------------------------------------------------------------------------
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_full  <= 1'b0;
            disp_codes <= {NUM_DIGITS{CODE_BLANK}};
            disp_point <= '0;
        end else if (frame.valid && frame.ready) begin
            pend_full <= 1'b1;
        end else if (frame_wrap && pend_full) begin
            pend_full  <= 1'b0;
            disp_codes <= pend_codes;           // swap at the frame boundary
            disp_point <= pend_point;
        end
    end

    always_ff @(posedge dri_clk) begin
        if (frame.valid && frame.ready) begin
            pend_codes <= fmt_codes;
            pend_point <= frame.point;
        end
    end

    assign frame.ready = !pend_full;
    assign codes       = disp_codes;
    assign point       = disp_point;

endmodule

//--- hdl/scan_mux.sv
// scan multiplexer
// divides the clock into digit steps, walks digits 0..5 and drives
// registered active-low select and segment lines
`timescale 1ns/100ps

module scan_mux #(
    parameter int SCAN_DIV = 5000               // clocks per digit
) (
    input  logic                             dri_clk,
    input  logic                             rst_n,
    input  logic                             en,
    input  disp_pkg::code_frame_t            codes,
    input  logic [num_pkg::NUM_DIGITS-1:0]   point,
    output logic                             frame_wrap,
    output disp_pkg::sel_t                   sel,
    output disp_pkg::seg_t                   seg_led
);

    import num_pkg::*;
    import disp_pkg::*;

    localparam int               CNT_W    = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SCAN_DIV - 1);
    localparam int               IDX_W    = $clog2(NUM_DIGITS);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(NUM_DIGITS - 1);

    logic [CNT_W-1:0]  div_cnt;
    logic              tick;
    logic [IDX_W-1:0]  digit_idx;
    disp_code_t        cur_code;
    logic              cur_point;
    seg_t              cur_seg;

    // ------------------------------------------------------------------------
    // tick divider and digit counter
    // ------------------------------------------------------------------------
    assign tick       = (div_cnt == CNT_LAST);
    assign frame_wrap = tick && (digit_idx == IDX_LAST);   // back to digit 0

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt   <= '0;
            digit_idx <= '0;
        end else if (tick) begin
            div_cnt   <= '0;
            digit_idx <= (digit_idx == IDX_LAST) ? '0 : digit_idx + 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // digit select and decode
    // ------------------------------------------------------------------------
    assign cur_code  = codes[digit_idx];
    assign cur_point = point[digit_idx];

    seg_decoder u_seg_decoder (
        .code     (cur_code),
        .point_on (cur_point),
        .seg      (cur_seg)
    );

    // sel and seg_led registered together so they stay aligned
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            sel     <= '1;
            seg_led <= SEG_BLANK;
        end else if (en) begin
            sel     <= ~(sel_t'(1) << digit_idx);
            seg_led <= cur_seg;
        end else begin
            sel     <= '1;                      // all digits off
            seg_led <= SEG_BLANK;
        end
    end

endmodule

//--- hdl/seg_display_top.sv
// six-digit seven-segment display driver
// binary value in over valid/ready, multiplexed active-low digits out
`timescale 1ns/100ps

module seg_display_top #(
    parameter int SCAN_DIV = 5000
) (
    input  logic                             dri_clk,
    input  logic                             rst_n,
    input  logic [num_pkg::VALUE_W-1:0]      value_data,
    input  logic [num_pkg::NUM_DIGITS-1:0]   value_point,
    input  logic                             value_sign,
    input  logic                             value_valid,
    output logic                             value_ready,
    input  logic                             en,
    output disp_pkg::sel_t                   sel,
    output disp_pkg::seg_t                   seg_led
);

    import num_pkg::*;
    import disp_pkg::*;

    code_frame_t             codes;
    logic [NUM_DIGITS-1:0]   point;
    logic                    frame_wrap;

    bcd_frame_if bcd_frame ();

    bin_to_bcd u_bin_to_bcd (
        .dri_clk     (dri_clk),
        .rst_n       (rst_n),
        .value_data  (value_data),
        .value_point (value_point),
        .value_sign  (value_sign),
        .value_valid (value_valid),
        .value_ready (value_ready),
        .frame       (bcd_frame.src)
    );

    digit_formatter u_digit_formatter (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .frame      (bcd_frame.dst),
        .frame_wrap (frame_wrap),
        .codes      (codes),
        .point      (point)
    );

    scan_mux #(
        .SCAN_DIV (SCAN_DIV)
    ) u_scan_mux (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .en         (en),
        .codes      (codes),
        .point      (point),
        .frame_wrap (frame_wrap),
        .sel        (sel),
        .seg_led    (seg_led)
    );

endmodule

//--- sim/seg_display_checker.sv
// concurrent checks on the bcd frame handshake and the scan outputs
// one copy sits in the converter, one in the scan multiplexer
`timescale 1ns/100ps

module seg_display_checker (
    input  logic                                      dri_clk,
    input  logic                                      rst_n,
    input  logic                                      frame_valid,
    input  logic                                      frame_ready,
    input  logic [5*num_pkg::NUM_DIGITS:0]            frame_data,   // {digits, point, sign}
    input  logic                                      frame_wrap,
    input  logic [num_pkg::NUM_DIGITS-1:0]            sel
);

    int fail_cnt = 0;       // read by the testbench at the end

    // payload frozen while the formatter holds off
    frame_hold: assert property (@(posedge dri_clk) disable iff (!rst_n)
        (frame_valid && !frame_ready) |=> (frame_valid && $stable(frame_data)))
    else begin
        $error("bcd frame changed or dropped valid before it was accepted");
        fail_cnt++;
    end

    sel_single: assert property (@(posedge dri_clk) disable iff (!rst_n)
        $countones(~sel) <= 1)
    else begin
        $error("more than one digit select active at once");
        fail_cnt++;
    end

    wrap_pulse: assert property (@(posedge dri_clk) disable iff (!rst_n)
        frame_wrap |=> !frame_wrap)
    else begin
        $error("frame_wrap stayed high for more than one cycle");
        fail_cnt++;
    end

endmodule

// converter side, scan signals tied off
bind bin_to_bcd seg_display_checker frame_chk (
    .dri_clk     (dri_clk),
    .rst_n       (rst_n),
    .frame_valid (frame.valid),
    .frame_ready (frame.ready),
    .frame_data  ({frame.digits, frame.point, frame.sign}),
    .frame_wrap  (1'b0),
    .sel         ('1)
);

// scan side, handshake tied idle
bind scan_mux seg_display_checker scan_chk (
    .dri_clk     (dri_clk),
    .rst_n       (rst_n),
    .frame_valid (1'b0),
    .frame_ready (1'b1),
    .frame_data  ('0),
    .frame_wrap  (frame_wrap),
    .sel         (sel)
);

//--- sim/seg_display_tb.sv
// testbench for the six-digit display driver
// sends values over the handshake and reads the display back off sel and seg_led
`timescale 1ns/100ps

module seg_display_tb;

    localparam int SCAN_DIV    = 4;
    localparam int FRAME_CYC   = 6 * SCAN_DIV;
    localparam int SETTLE_CYC  = 22 + 2 * FRAME_CYC;    // conversion plus two frames
    localparam int N_SENDS     = 12;
    localparam int TIMEOUT_CYC = 50 + N_SENDS * (SETTLE_CYC + 3 * FRAME_CYC);
    localparam int CODE_BLANK  = 10;
    localparam int CODE_MINUS  = 11;

    logic        dri_clk;
    logic        rst_n;
    logic [19:0] value_data;
    logic [5:0]  value_point;
    logic        value_sign;
    logic        value_valid;
    logic        value_ready;
    logic        en;
    logic [5:0]  sel;
    logic [7:0]  seg_led;

    int          err_cnt;
    int          chk_cnt;
    int          asrt_cnt;
    int          cycles = 0;
    int          seed;
    logic [7:0]  cap [6];          // captured pattern per digit
    logic [7:0]  exp_seg [6];

    seg_display_top #(
        .SCAN_DIV (SCAN_DIV)
    ) dut0 (
        .dri_clk     (dri_clk),
        .rst_n       (rst_n),
        .value_data  (value_data),
        .value_point (value_point),
        .value_sign  (value_sign),
        .value_valid (value_valid),
        .value_ready (value_ready),
        .en          (en),
        .sel         (sel),
        .seg_led     (seg_led)
    );

    initial begin
        dri_clk = 1'b0;
        forever #10 dri_clk = ~dri_clk;
    end

    always @(posedge dri_clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYC) begin
            $display("timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // display reference model
    // ------------------------------------------------------------------------
    function automatic logic [7:0] seg_pattern(input int code, input logic pt);
        logic [7:0] s;
        case (code)
            0:          s = 8'hC0;
            1:          s = 8'hF9;
            2:          s = 8'hA4;
            3:          s = 8'hB0;
            4:          s = 8'h99;
            5:          s = 8'h92;
            6:          s = 8'h82;
            7:          s = 8'hF8;
            8:          s = 8'h80;
            9:          s = 8'h90;
            CODE_MINUS: s = 8'hBF;      // g only
            default:    s = 8'hFF;
        endcase
        if (code <= 9 && pt) begin
            s[7] = 1'b0;
        end
        return s;
    endfunction

    task automatic build_expected(input logic [19:0] v, input logic [5:0] pt, input logic sg);
        int val;
        int k;
        int dig [6];
        val = int'(v);
        if (val > 999999) begin
            val = 999999;               // saturate
        end
        for (int p = 0; p < 6; p++) begin
            dig[p] = val % 10;
            val = val / 10;
        end
        k = 0;
        for (int p = 5; p >= 1; p--) begin
            if (k == 0 && (dig[p] != 0 || pt[p])) begin
                k = p;
            end
        end
        for (int p = 0; p < 6; p++) begin
            if (p <= k) begin
                exp_seg[p] = seg_pattern(dig[p], pt[p]);
            end else if (sg && p == k + 1) begin
                exp_seg[p] = seg_pattern(CODE_MINUS, 1'b0);
            end else begin
                exp_seg[p] = seg_pattern(CODE_BLANK, 1'b0);
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // stimulus and capture helpers
    // ------------------------------------------------------------------------
    task automatic send_value(input logic [19:0] v, input logic [5:0] pt, input logic sg);
        @(negedge dri_clk);
        value_data  = v;
        value_point = pt;
        value_sign  = sg;
        value_valid = 1'b1;
        while (!value_ready) begin
            @(negedge dri_clk);
        end
        @(negedge dri_clk);             // transfer took place on the edge before
        value_valid = 1'b0;
    endtask

    task automatic capture_frame();
        logic [5:0] seen;
        seen = '0;
        repeat (FRAME_CYC) begin
            @(negedge dri_clk);
            for (int i = 0; i < 6; i++) begin
                if (!sel[i]) begin
                    cap[i]  = seg_led;
                    seen[i] = 1'b1;
                end
            end
        end
        chk_cnt++;
        assert (seen == 6'h3F) else begin
            $display("some digits were never selected during a whole frame, seen %b", seen);
            err_cnt++;
        end
    endtask

    task automatic compare_display(input string name, input logic [19:0] v,
                                   input logic [5:0] pt, input logic sg);
        repeat (SETTLE_CYC) @(negedge dri_clk);
        build_expected(v, pt, sg);
        capture_frame();
        for (int i = 0; i < 6; i++) begin
            chk_cnt++;
            assert (cap[i] === exp_seg[i]) else begin
                $display("[FAIL] %s digit %0d: expected %h, actual %h",
                         name, i, exp_seg[i], cap[i]);
                err_cnt++;
            end
        end
    endtask

    task automatic show_value(input string name, input logic [19:0] v,
                              input logic [5:0] pt, input logic sg);
        send_value(v, pt, sg);
        compare_display(name, v, pt, sg);
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic check_reset_state();
        chk_cnt++;
        assert (sel == 6'h3F && seg_led == 8'hFF && value_ready) else begin
            $display("[FAIL] reset: expected sel 3f seg ff ready 1, actual sel %h seg %h ready %b",
                     sel, seg_led, value_ready);
            err_cnt++;
        end
    endtask

    task automatic saturate_and_disable();
        show_value("saturate", 20'hFFFFF, 6'h00, 1'b0);
        @(negedge dri_clk);
        en = 1'b0;
        @(negedge dri_clk);             // sel is registered
        repeat (FRAME_CYC) begin
            @(negedge dri_clk);
            chk_cnt++;
            assert (sel == 6'h3F) else begin
                $display("[FAIL] disable: expected sel 3f, actual %h", sel);
                err_cnt++;
            end
        end
        en = 1'b1;
    endtask

    task automatic stream_random_values();
        logic [31:0] rnd;
        for (int n = 0; n < 5; n++) begin
            rnd = $random(seed);
            send_value(rnd[19:0], rnd[25:20], rnd[26]);    // no wait between values
        end
        rnd = $random(seed);
        show_value("random", rnd[19:0], rnd[25:20], rnd[26]);
    endtask

    initial begin
        rst_n       = 1'b0;
        value_data  = '0;
        value_point = '0;
        value_sign  = 1'b0;
        value_valid = 1'b0;
        en          = 1'b1;
        err_cnt     = 0;
        chk_cnt     = 0;
        seed        = 32'hfe8b;
        repeat (3) @(posedge dri_clk);  // three rising edges under reset
        @(negedge dri_clk);
        rst_n = 1'b1;

        check_reset_state();
        show_value("plain", 20'd1234, 6'h00, 1'b0);
        show_value("sign", 20'd56, 6'h00, 1'b1);
        show_value("sign_full", 20'd654321, 6'h00, 1'b1);
        show_value("point", 20'd7, 6'b001000, 1'b0);
        saturate_and_disable();
        stream_random_values();

        asrt_cnt = dut0.u_bin_to_bcd.frame_chk.fail_cnt + dut0.u_scan_mux.scan_chk.fail_cnt;
        $display("checks run %0d, failed %0d, assertion failures %0d",
                 chk_cnt, err_cnt, asrt_cnt);
        if (err_cnt == 0 && asrt_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- build.f
hdl/num_pkg.sv
hdl/disp_pkg.sv
hdl/bcd_frame_if.sv
hdl/seg_decoder.sv
hdl/bin_to_bcd.sv
hdl/digit_formatter.sv
hdl/scan_mux.sv
hdl/seg_display_top.sv
sim/seg_display_checker.sv
sim/seg_display_tb.sv

//--- Makefile
# Verilator build and run for the seven-segment display driver

SIM := obj_dir/Vseg_display_tb

.PHONY: all run clean

all: run

$(SIM): build.f $(wildcard hdl/*.sv sim/*.sv)
	verilator --binary --timing --assert --top-module seg_display_tb \
		-Mdir obj_dir -f build.f

run: $(SIM)
	$(SIM) +verilator+error+limit+100 | tee sim.log
	@grep -q "^Simulation finished: PASS$$" sim.log || \
		{ echo "run did not pass, see sim.log"; exit 1; }

clean:
	rm -rf obj_dir sim.log
